//--- vlog.f
+incdir+.
ooo_pkg.sv
register_file.sv
reorder_buffer.sv
operand_lookup.sv
issue_stage.sv
tb_issue_stage.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_issue_stage
RTL_TOP    := issue_stage
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defines.svh"

module tb_issue_stage;

  logic clk_in = 1'b0;
  logic rst_in, issue_valid, writes_rd, complete_valid, flush;
  logic [`REG_AW-1:0] issue_rs1, issue_rs2, issue_rd, commit_rd;
  logic [`ROB_TW-1:0] complete_tag, issue_tag, src1_tag, src2_tag;
  logic [`XLEN-1:0]   complete_data, src1_value, src2_value, commit_data;
  logic issue_ready, src1_ready, src2_ready, commit_valid;

  // reference model of the architectural state and the rob
  logic [`XLEN-1:0]     m_regs [`NUM_REGS];
  logic [`ROB_TW-1:0]   m_tag [`NUM_REGS];
  logic [`NUM_REGS-1:0] m_busy;
  ooo_pkg::rob_state_e  m_state [`ROB_DEPTH];
  logic [`REG_AW-1:0]   m_rd [`ROB_DEPTH];
  logic                 m_wr [`ROB_DEPTH];
  logic [`XLEN-1:0]     m_val [`ROB_DEPTH];
  logic [`ROB_TW-1:0]   m_head, m_tail;
  int m_count = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int test_base = 0;                              // fail count when the test began
  logic [31:0] lfsr = 32'd86027;

  issue_stage i_issue_stage (.*);

  always #5 clk_in = ~clk_in;                     // 10 ns period

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [`REG_AW-1:0] rand_reg();
    return `REG_AW'(rand_bits(`REG_AW));
  endfunction

  // first pending slot from a random start, any slot if none pending
  function automatic logic [`ROB_TW-1:0] pick_pending();
    logic [`ROB_TW-1:0] t;
    t = `ROB_TW'(rand_bits(`ROB_TW));
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      if (m_state[t] == ooo_pkg::ROB_PENDING) return t;
      t = t + `ROB_TW'(1);
    end
    return t;
  endfunction

  task automatic check(input bit ok, input string what);
    assert (ok) pass_cnt++;
    else begin
      fail_cnt++;
      $display("Fail %0t: %s", $time, what);
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < `NUM_REGS; i++) begin
      m_regs[i] = '0;
      m_tag[i]  = '0;
    end
    for (int i = 0; i < `ROB_DEPTH; i++) m_state[i] = ooo_pkg::ROB_EMPTY;
    m_busy  = '0;
    m_head  = '0;
    m_tail  = '0;
    m_count = 0;
  endtask

  // x0, architectural value, forwarded rob value or wait on tag
  task automatic src_check(input string name, input logic [`REG_AW-1:0] rs,
                           input logic [`XLEN-1:0] v, input logic [`ROB_TW-1:0] t, input logic r);
    logic [`XLEN-1:0] ev;
    logic er;
    ev = '0;
    er = 1'b1;
    if (rs != 0 && m_busy[rs]) begin
      if (m_state[m_tag[rs]] == ooo_pkg::ROB_DONE) ev = m_val[m_tag[rs]];
      else er = 1'b0;                              // producer still pending
    end else if (rs != 0) ev = m_regs[rs];
    check(r == er && (er ? v == ev : t == m_tag[rs]),
          $sformatf("%s x%0d ready %0b value %0h tag %0d, expected %0b %0h %0d",
                    name, rs, r, v, t, er, ev, m_tag[rs]));
  endtask

  task automatic compare_outputs();
    logic rdy;
    logic cv;
    rdy = (m_count < `ROB_DEPTH) && !flush;
    cv  = !flush && (m_state[m_head] == ooo_pkg::ROB_DONE) && m_wr[m_head];
    check(issue_ready == rdy, $sformatf("issue_ready %0b, expected %0b", issue_ready, rdy));
    if (issue_valid && rdy)
      check(issue_tag == m_tail, $sformatf("issue_tag %0d, expected %0d", issue_tag, m_tail));
    check(commit_valid == cv, $sformatf("commit_valid %0b, expected %0b", commit_valid, cv));
    if (cv)
      check(commit_rd == m_rd[m_head] && commit_data == m_val[m_head],
            $sformatf("commit x%0d=%0h, expected x%0d=%0h",
                      commit_rd, commit_data, m_rd[m_head], m_val[m_head]));
    src_check("src1", issue_rs1, src1_value, src1_tag, src1_ready);
    src_check("src2", issue_rs2, src2_value, src2_tag, src2_ready);
  endtask

  // what the coming clock edge does to the model
  task automatic model_edge();
    logic ret;
    logic acc;
    logic [`ROB_TW-1:0] h;
    logic [`REG_AW-1:0] d;
    h   = m_head;
    ret = (m_state[h] == ooo_pkg::ROB_DONE);       // sampled before completion lands
    acc = issue_valid && (m_count < `ROB_DEPTH);
    if (flush) begin
      model_reset_rob();
    end else begin
      if (complete_valid && m_state[complete_tag] == ooo_pkg::ROB_PENDING) begin
        m_val[complete_tag]   = complete_data;
        m_state[complete_tag] = ooo_pkg::ROB_DONE;
      end
      if (ret) begin
        d = m_rd[h];
        if (m_wr[h] && d != 0) begin
          m_regs[d] = m_val[h];
          if (m_tag[d] == h) m_busy[d] = 1'b0;    // newer rename keeps it busy
        end
        m_state[h] = ooo_pkg::ROB_EMPTY;
        m_head     = m_head + `ROB_TW'(1);
      end
      if (acc) begin
        m_state[m_tail] = ooo_pkg::ROB_PENDING;
        m_rd[m_tail]    = issue_rd;
        m_wr[m_tail]    = writes_rd;
        if (writes_rd && issue_rd != 0) begin     // issue wins over commit
          m_tag[issue_rd]  = m_tail;
          m_busy[issue_rd] = 1'b1;
        end
        m_tail = m_tail + `ROB_TW'(1);
      end
      m_count = m_count + int'(acc) - int'(ret);
    end
  endtask

  task automatic model_reset_rob();
    for (int i = 0; i < `ROB_DEPTH; i++) m_state[i] = ooo_pkg::ROB_EMPTY;
    m_busy  = '0;                                  // every busy reg has a live slot
    m_head  = '0;
    m_tail  = '0;
    m_count = 0;
  endtask

  // one clock: drive after the edge, check mid cycle, then advance the model
  task automatic cycle(input logic iv, input logic [`REG_AW-1:0] r1, r2, rd, input logic wr,
                       input logic cv, input logic [`ROB_TW-1:0] ct,
                       input logic [`XLEN-1:0] cd, input logic fl);
    @(posedge clk_in);
    issue_valid    <= iv;
    issue_rs1      <= r1;
    issue_rs2      <= r2;
    issue_rd       <= rd;
    writes_rd      <= wr;
    complete_valid <= cv;
    complete_tag   <= ct;
    complete_data  <= cd;
    flush          <= fl;
    @(negedge clk_in);
    compare_outputs();
    model_edge();
  endtask

  task automatic idle(input logic [`REG_AW-1:0] r1, r2);
    cycle(0, r1, r2, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic wait_commit();
    int n;
    n = 0;
    do begin
      idle(0, 0);
      n++;
    end while (!commit_valid && n < 20);
    if (!commit_valid) begin
      fail_cnt++;
      $display("timeout at %0t: no commit within 20 cycles", $time);
    end
  endtask

  // complete pending slots until the rob is empty
  task automatic drain();
    int n;
    n = 0;
    while (m_count != 0 && n < 100) begin
      cycle(0, 0, 0, 0, 0, 1, pick_pending(), rand_bits(32), 0);
      n++;
    end
    if (m_count != 0) begin
      fail_cnt++;
      $display("timeout at %0t: reorder buffer did not drain in 100 cycles", $time);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  initial begin
    logic [`ROB_TW-1:0] tag_a, tag_b;
    logic [`XLEN-1:0]   data_b;
    rst_in         = 1'b1;
    issue_valid    = 1'b0;
    issue_rs1      = '0;
    issue_rs2      = '0;
    issue_rd       = '0;
    writes_rd      = 1'b0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    complete_data  = '0;
    flush          = 1'b0;
    model_reset();
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;

    for (int i = 0; i < `NUM_REGS; i++) idle(`REG_AW'(i), `REG_AW'(`NUM_REGS - 1 - i));
    end_test("reset_state");

    for (int i = 0; i < 400; i++)                  // ~75% issue, ~50% complete
      cycle(rand_bits(2) != 0, rand_reg(), rand_reg(), rand_reg(), rand_bits(3) != 0,
            rand_bits(1) != 0, pick_pending(), rand_bits(32), 0);
    drain();
    for (int i = 0; i < `NUM_REGS; i++) idle(`REG_AW'(i), `REG_AW'(i));
    end_test("random_commit");

    tag_a = m_tail;                                // slot the older producer gets
    cycle(1, 0, 0, 5, 1, 0, 0, 0, 0);
    tag_b = m_tail;                                // younger producer of x5
    cycle(1, 0, 0, 5, 1, 0, 0, 0, 0);
    cycle(0, 5, 0, 0, 0, 1, tag_a, rand_bits(32), 0);
    wait_commit();
    idle(5, 0);
    check(!src1_ready && src1_tag == tag_b, "x5 lost its newer rename after the older commit");
    data_b = rand_bits(32);
    cycle(0, 0, 0, 0, 0, 1, tag_b, data_b, 0);
    wait_commit();
    idle(5, 0);
    check(src1_ready && src1_value == data_b, "x5 not ready with the newer result");
    end_test("rename_overwrite");

    for (int i = 0; i < `ROB_DEPTH; i++) cycle(1, 0, 0, rand_reg(), 1, 0, 0, 0, 0);
    cycle(1, 0, 0, 7, 1, 0, 0, 0, 0);              // dropped, model stays full
    check(!issue_ready, "issue_ready high with a full reorder buffer");
    cycle(0, 7, 0, 0, 0, 1, m_head, rand_bits(32), 0);  // x7 as the model holds it
    wait_commit();
    idle(0, 0);
    check(issue_ready, "issue_ready did not return after a commit");
    drain();
    end_test("back_pressure");

    for (int i = 0; i < 6; i++)
      cycle(1, rand_reg(), rand_reg(), rand_reg(), 1,
            rand_bits(1) != 0, pick_pending(), rand_bits(32), 0);
    cycle(1, 0, 0, 3, 1, 1, pick_pending(), rand_bits(32), 1);  // issue and complete ignored
    for (int i = 0; i < `NUM_REGS; i++) idle(`REG_AW'(i), `REG_AW'(i));
    for (int i = 0; i < `ROB_DEPTH; i++) cycle(0, 0, 0, 0, 0, 1, `ROB_TW'(i), rand_bits(32), 0);
    cycle(1, 0, 0, 4, 1, 0, 0, 0, 0);              // tag checked against model tail
    drain();
    end_test("flush");

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- issue_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defines.svh"

module issue_stage (
  input  wire                 clk_in,
  input  wire                 rst_in,
  input  wire                 issue_valid,
  input  wire [`REG_AW-1:0]   issue_rs1,
  input  wire [`REG_AW-1:0]   issue_rs2,
  input  wire [`REG_AW-1:0]   issue_rd,
  input  wire                 writes_rd,
  input  wire                 complete_valid,
  input  wire [`ROB_TW-1:0]   complete_tag,
  input  wire [`XLEN-1:0]     complete_data,
  input  wire                 flush,
  output logic                issue_ready,
  output logic [`ROB_TW-1:0]  issue_tag,
  output logic [`XLEN-1:0]    src1_value,
  output logic [`ROB_TW-1:0]  src1_tag,
  output logic                src1_ready,
  output logic [`XLEN-1:0]    src2_value,
  output logic [`ROB_TW-1:0]  src2_tag,
  output logic                src2_ready,
  output logic                commit_valid,
  output logic [`REG_AW-1:0]  commit_rd,
  output logic [`XLEN-1:0]    commit_data
);

  localparam int SW = $bits(ooo_pkg::rob_state_e);

  logic                      issue_accept;              // rob took the issue
  logic [`ROB_TW-1:0]        commit_tag;
  logic [`ROB_DEPTH*SW-1:0]  entry_states;
  logic [`XLEN-1:0]          entry_values [`ROB_DEPTH];
  logic [`REG_AW-1:0]        entry_rds [`ROB_DEPTH];    // flush list for the rf
  logic [`XLEN-1:0]          rval1, rval2;
  logic [`ROB_TW-1:0]        tag1, tag2;
  logic                      busy1, busy2;

  register_file i_register_file (
    .clk_in, .rst_in,
    .rs1 (issue_rs1), .rs2 (issue_rs2),
    .commit_valid, .commit_rd, .commit_tag, .commit_data,
    .rename_valid (issue_accept), .rename_rd (issue_rd), .rename_tag (issue_tag),
    .writes_rd, .flush, .flush_addrs (entry_rds),
    .rval1, .rval2, .tag1, .tag2, .busy1, .busy2
  );

  reorder_buffer #(.SW (SW)) i_reorder_buffer (
    .clk_in, .rst_in,
    .issue_valid, .issue_rd, .writes_rd,
    .complete_valid, .complete_tag, .complete_data, .flush,
    .issue_ready, .issue_accept, .issue_tag,
    .commit_valid, .commit_rd, .commit_tag, .commit_data,
    .entry_states, .entry_values, .entry_rds
  );

  // one lookup per source operand
  operand_lookup #(.SW (SW)) i_lookup_src1 (
    .rs (issue_rs1), .rf_value (rval1), .rf_tag (tag1), .rf_busy (busy1),
    .entry_states, .entry_values,
    .value (src1_value), .tag (src1_tag), .ready (src1_ready)
  );

  operand_lookup #(.SW (SW)) i_lookup_src2 (
    .rs (issue_rs2), .rf_value (rval2), .rf_tag (tag2), .rf_busy (busy2),
    .entry_states, .entry_values,
    .value (src2_value), .tag (src2_tag), .ready (src2_ready)
  );

endmodule

`default_nettype wire

//--- operand_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defines.svh"

module operand_lookup #(
  parameter int SW = $bits(ooo_pkg::rob_state_e)  // bits per slot state
) (
  input  wire [`REG_AW-1:0]        rs,                        // source register
  input  wire [`XLEN-1:0]          rf_value,
  input  wire [`ROB_TW-1:0]        rf_tag,                    // producer slot if busy
  input  wire                      rf_busy,
  input  wire [`ROB_DEPTH*SW-1:0]  entry_states,              // flat from the rob
  input  wire [`XLEN-1:0]          entry_values [`ROB_DEPTH],
  output logic [`XLEN-1:0]         value,
  output logic [`ROB_TW-1:0]       tag,
  output logic                     ready
);

  ooo_pkg::rob_state_e prod_state;  // state of the producing slot

  assign prod_state = ooo_pkg::rob_state_e'(entry_states[rf_tag*SW +: SW]);
  assign tag        = rf_tag;       // only meaningful while not ready

  always_comb begin
    if (rs == '0) begin
      value = '0;                     // x0 reads zero
      ready = 1'b1;
    end else if (!rf_busy) begin
      value = rf_value;               // architectural value is current
      ready = 1'b1;
    end else if (prod_state == ooo_pkg::ROB_DONE) begin
      value = entry_values[rf_tag];   // forward result not yet retired
      ready = 1'b1;
    end else begin
      value = '0;                     // wait on tag
      ready = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defines.svh"

module reorder_buffer #(
  parameter int SW = $bits(ooo_pkg::rob_state_e)  // bits per exported state
) (
  input  wire                        clk_in,
  input  wire                        rst_in,
  input  wire                        issue_valid,       // issue strobe from outside
  input  wire [`REG_AW-1:0]          issue_rd,
  input  wire                        writes_rd,
  input  wire                        complete_valid,    // result from an execution unit
  input  wire [`ROB_TW-1:0]          complete_tag,
  input  wire [`XLEN-1:0]            complete_data,
  input  wire                        flush,             // discard everything in flight
  output logic                       issue_ready,
  output logic                       issue_accept,      // issue actually allocated
  output logic [`ROB_TW-1:0]         issue_tag,         // slot given to this issue
  output logic                       commit_valid,
  output logic [`REG_AW-1:0]         commit_rd,
  output logic [`ROB_TW-1:0]         commit_tag,
  output logic [`XLEN-1:0]           commit_data,
  output logic [`ROB_DEPTH*SW-1:0]   entry_states,      // slot i at [i*SW +: SW]
  output logic [`XLEN-1:0]           entry_values [`ROB_DEPTH],
  output logic [`REG_AW-1:0]         entry_rds [`ROB_DEPTH]
);

  logic [`ROB_TW-1:0] head;    // oldest slot
  logic [`ROB_TW-1:0] tail;    // next slot to allocate
  logic [`ROB_TW:0]   count;   // one extra bit to tell full from empty

  ooo_pkg::rob_state_e state [`ROB_DEPTH];
  logic [`REG_AW-1:0]  rd    [`ROB_DEPTH];  // destination register
  logic                wr    [`ROB_DEPTH];  // slot writes the register file
  logic [`XLEN-1:0]    val   [`ROB_DEPTH];  // captured result

  logic full;
  logic retire;       // head leaves this cycle
  logic complete_en;  // completion hits a pending slot

  assign full         = (count == (`ROB_TW+1)'(`ROB_DEPTH));
  assign issue_ready  = !full && !flush;     // flush cycle blocks allocation
  assign issue_accept = issue_valid && issue_ready;
  assign issue_tag    = tail;

  assign retire       = (state[head] == ooo_pkg::ROB_DONE) && !flush;
  assign complete_en  = complete_valid && !flush &&
                        (state[complete_tag] == ooo_pkg::ROB_PENDING);

  // slots without a destination retire silently
  assign commit_valid = retire && wr[head];
  assign commit_rd    = rd[head];
  assign commit_tag   = head;
  assign commit_data  = val[head];

  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      entry_states[i*SW +: SW] = state[i];
      entry_values[i]          = val[i];
      entry_rds[i]             = rd[i];
    end
  end

  // control state, all cleared by reset and by flush
  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        state[i] <= ooo_pkg::ROB_EMPTY;
      end
    end else begin
      if (complete_en) begin
        state[complete_tag] <= ooo_pkg::ROB_DONE;
      end
      if (retire) begin
        state[head] <= ooo_pkg::ROB_EMPTY;
        head        <= head + `ROB_TW'(1);  // wraps at depth
      end
      if (issue_accept) begin
        state[tail] <= ooo_pkg::ROB_PENDING; // tail is never head while in use
        tail        <= tail + `ROB_TW'(1);
      end
      case ({issue_accept, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // both or neither
      endcase
    end
  end

  // slot payload, only meaningful while the slot is in use
  always_ff @(posedge clk_in) begin
    if (issue_accept) begin
      rd[tail] <= issue_rd;
      wr[tail] <= writes_rd;
    end
    if (complete_en) begin
      val[complete_tag] <= complete_data;
    end
  end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defines.svh"

module register_file (
  input  wire                 clk_in,
  input  wire                 rst_in,
  input  wire [`REG_AW-1:0]   rs1,                      // read port 1 address
  input  wire [`REG_AW-1:0]   rs2,                      // read port 2 address
  input  wire                 commit_valid,             // retire strobe from rob
  input  wire [`REG_AW-1:0]   commit_rd,
  input  wire [`ROB_TW-1:0]   commit_tag,               // rob slot being retired
  input  wire [`XLEN-1:0]     commit_data,
  input  wire                 rename_valid,             // issue accepted this cycle
  input  wire [`REG_AW-1:0]   rename_rd,
  input  wire [`ROB_TW-1:0]   rename_tag,               // slot allocated to the issue
  input  wire                 writes_rd,                // issued op has a destination
  input  wire                 flush,
  input  wire [`REG_AW-1:0]   flush_addrs [`ROB_DEPTH], // dest of every rob slot
  output logic [`XLEN-1:0]    rval1,
  output logic [`XLEN-1:0]    rval2,
  output logic [`ROB_TW-1:0]  tag1,
  output logic [`ROB_TW-1:0]  tag2,
  output logic                busy1,
  output logic                busy2
);

  logic [`XLEN-1:0]   regs [`NUM_REGS];  // architectural values
  logic [`ROB_TW-1:0] tags [`NUM_REGS];  // youngest producer per register
  logic [`NUM_REGS-1:0] busy;            // set while a producer is in flight

  logic rename_en;
  logic commit_en;

  // x0 is hardwired, so it never takes a rename or a write
  assign rename_en = rename_valid && writes_rd && (rename_rd != '0);
  assign commit_en = commit_valid && (commit_rd != '0);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
      busy <= '0;
    end else if (flush) begin
      // every busy register has its producer in some slot
      for (int j = 0; j < `ROB_DEPTH; j++) begin
        busy[flush_addrs[j]] <= 1'b0;
      end
    end else begin
      if (commit_en) begin
        regs[commit_rd] <= commit_data;
        if (tags[commit_rd] == commit_tag) begin
          busy[commit_rd] <= 1'b0;      // no younger rename pending
        end
      end
      if (rename_en) begin               // later assignment, so issue wins
        tags[rename_rd] <= rename_tag;
        busy[rename_rd] <= 1'b1;
      end
    end
  end

  // read ports, x0 forced to zero and never busy
  always_comb begin
    rval1 = (rs1 == '0) ? '0 : regs[rs1];
    rval2 = (rs2 == '0) ? '0 : regs[rs2];
    tag1  = tags[rs1];
    tag2  = tags[rs2];
    busy1 = (rs1 != '0) && busy[rs1];
    busy2 = (rs2 != '0) && busy[rs2];
  end

endmodule

`default_nettype wire

//--- ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // life of one reorder buffer slot
  typedef enum logic [1:0] {
    ROB_EMPTY   = 2'd0, // free for allocation
    ROB_PENDING = 2'd1, // issued, result outstanding
    ROB_DONE    = 2'd2  // result captured, waiting for head
  } rob_state_e;

  // a slot goes EMPTY -> PENDING -> DONE -> EMPTY
  // or straight back to EMPTY on flush

endpackage

`default_nettype wire

//--- ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// architectural register file
`define NUM_REGS 32  // x0..x31
`define XLEN 32      // register width in bits
`define REG_AW 5     // bits to address one register

// reorder buffer sizing
`define ROB_DEPTH 8  // in-flight instructions
`define ROB_TW 3     // tag width, log2 of ROB_DEPTH

// ROB_TW and ROB_DEPTH must agree, since the pointers
// wrap by plain overflow of a ROB_TW-bit counter

`endif
